//--- all.f
+incdir+design
design/icache_pkg.sv
design/cache_line_if.sv
design/tag_store.sv
design/data_store.sv
design/cache_control.sv
design/icache_top.sv
testbench/icache_checker.sv
testbench/icache_tb.sv

//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/100ps
TOP       = icache_tb
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log
RUN_ARGS  = +verilator+error+limit+1000

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --assert --timescale 1ns/100ps --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/icache_tb.sv
`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_tb;

    localparam int TIMEOUT_CYCLES = 20; // the slowest memory answer takes six cycles.

    logic                      clock;
    logic                      reset;
    logic                      valid;
    logic [`ICACHE_ADDR_W-1:0] addr;
    logic                      ready;
    logic [31:0]               data;
    logic                      flush;
    logic                      mem_start;
    logic [`ICACHE_ADDR_W-1:0] mem_addr;
    logic                      mem_ok;
    logic [31:0]               mem_rdata;

    integer seed; // $random state that starts from a fixed seed.

    logic                     model_valid [`ICACHE_LINES]; // expected valid bit per line.
    logic [`ICACHE_TAG_W-1:0] model_tag [`ICACHE_LINES];   // expected tag per line.
    logic [31:0]              model_word [`ICACHE_LINES];  // expected word per line.

    int unsigned generation;    // memory contents change at every flush.
    logic        answered_last; // valid is still high from the request answered last.
    logic        hung;          // a wait ran out, so later fetches are skipped.
    string       test_name;
    int          error_count;
    int          errors_before; // error count when the current test began.
    int          tests_passed;
    int          tests_failed;
    int          hits;
    int          misses;

    icache_top u_dut (
        .clock     (clock),
        .reset     (reset),
        .valid     (valid),
        .addr      (addr),
        .ready     (ready),
        .data      (data),
        .flush     (flush),
        .mem_start (mem_start),
        .mem_addr  (mem_addr),
        .mem_ok    (mem_ok),
        .mem_rdata (mem_rdata)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock; // 20 ns period.
    end

    // every address bit and the flush generation shape the memory word.
    function automatic logic [31:0] memory_word(input logic [31:0] word_addr,
                                                input int unsigned gen);
        return (word_addr * 32'h9e37_79b1) ^ {word_addr[15:0], word_addr[31:16]}
               ^ (gen * 32'h0101_0101);
    endfunction

    task automatic clear_model();
        int i;
        for (i = 0; i < `ICACHE_LINES; i++) begin
            model_valid[i] = 1'b0; // an empty cache misses on every line.
            model_tag[i]   = '0;
            model_word[i]  = '0;
        end
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        errors_before = error_count;
    endtask

    task automatic finish_test();
        if (error_count == errors_before) begin
            tests_passed++;
            $display("test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name,
                     error_count - errors_before);
        end
    endtask

    // with no request pending the cache must stay silent.
    task automatic idle_cycles(input int count);
        int i;
        valid         = 1'b0;
        answered_last = 1'b0;
        for (i = 0; i < count; i++) begin
            @(negedge clock);
            if (ready || mem_start) begin
                error_count++;
                $display("%s: ready or mem_start went high with no request pending", test_name);
            end
        end
    endtask

    task automatic flush_cache();
        valid         = 1'b0;
        answered_last = 1'b0;
        flush         = 1'b1; // a one-cycle pulse acts like a fence.i.
        @(negedge clock);
        flush = 1'b0;
        generation++;
        clear_model();
    endtask

    // the memory answers after 1 to 6 cycles with a one-cycle mem_ok.
    task automatic answer_memory(input logic [31:0] word_addr);
        int latency;
        latency = 1 + int'($unsigned($random(seed)) % 6);
        repeat (latency) @(negedge clock);
        mem_ok    = 1'b1;
        mem_rdata = memory_word(word_addr, generation);
        @(negedge clock);
        mem_ok    = 1'b0;
        mem_rdata = 32'h0;
    endtask

    // one request holds valid, serves a miss and compares the answer with the model.
    task automatic fetch(input logic [`ICACHE_ADDR_W-1:0] fetch_addr);
        logic [`ICACHE_INDEX_W-1:0] idx;
        logic [`ICACHE_TAG_W-1:0]   tag;
        logic [`ICACHE_ADDR_W-1:0]  word_addr;
        logic                       expect_hit;
        logic [31:0]                expect_word;
        logic                       saw_start;
        logic                       saw_ready;
        int                         cycles;
        int                         expect_cycles;

        if (hung) return;
        idx         = fetch_addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
        tag         = fetch_addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
        word_addr   = {fetch_addr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W],
                       {`ICACHE_OFFSET_W{1'b0}}};
        expect_hit  = model_valid[idx] && (model_tag[idx] == tag);
        expect_word = expect_hit ? model_word[idx] : memory_word(word_addr, generation);
        expect_cycles = answered_last ? 2 : 1; // a respond cycle comes first when back to back.

        valid     = 1'b1;
        addr      = fetch_addr;
        saw_start = 1'b0;
        saw_ready = 1'b0;
        cycles    = 0;
        while (!saw_ready && !saw_start && cycles < TIMEOUT_CYCLES) begin
            @(negedge clock);
            cycles++;
            saw_start = mem_start;
            saw_ready = ready;
        end
        // a hit answers and a miss starts its read in the cycle after valid is sampled.
        if ((saw_start || saw_ready) && cycles != expect_cycles) begin
            error_count++;
            $display("ERROR %s: request latency expected %0d actual %0d", test_name,
                     expect_cycles, cycles);
        end
        if (saw_start) begin
            if (mem_addr !== word_addr) begin
                error_count++;
                $display("ERROR %s: mem_addr expected %h actual %h", test_name,
                         word_addr, mem_addr);
            end
            answer_memory(mem_addr);
            if (!ready) begin
                error_count++;
                $display("%s: ready did not rise one cycle after mem_ok", test_name);
            end
            cycles = 0;
            while (!ready && cycles < TIMEOUT_CYCLES) begin
                @(negedge clock);
                cycles++;
            end
            saw_ready = ready;
        end
        if (!saw_ready) begin
            hung = 1'b1;
            error_count++;
            $display("%s: fetch of %h got no answer within %0d cycles", test_name, fetch_addr,
                     TIMEOUT_CYCLES);
            return;
        end
        if (saw_start == expect_hit) begin
            error_count++;
            $display("ERROR %s: hit expected %0d actual %0d", test_name, expect_hit, !saw_start);
        end
        if (data !== expect_word) begin
            error_count++;
            $display("ERROR %s: data expected %h actual %h", test_name, expect_word, data);
        end
        if (expect_hit) begin
            hits++;
        end else begin
            misses++;
            model_valid[idx] = 1'b1; // the miss fills the line.
            model_tag[idx]   = tag;
            model_word[idx]  = expect_word;
        end
        answered_last = 1'b1;
    endtask

    initial begin
        int                       n;
        int                       assert_fails;
        logic [31:0]              r;
        logic [`ICACHE_TAG_W-1:0] pick_tag;

        seed = 32'h3370;
        reset = 1'b1;
        valid = 1'b0;
        addr = '0;
        flush = 1'b0;
        mem_ok = 1'b0;
        mem_rdata = 32'h0;
        generation = 0;
        answered_last = 1'b0;
        hung = 1'b0;
        error_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        hits = 0;
        misses = 0;
        clear_model();
        repeat (4) @(negedge clock);
        reset = 1'b0;

        start_test("reset_state");
        idle_cycles(4);
        fetch(32'h0000_1234); // the model is empty, so each of these must miss.
        idle_cycles(1);
        fetch(32'h00ab_c018);
        finish_test();

        start_test("miss_then_fill");
        idle_cycles(2);
        fetch(32'h0040_0a47); // odd byte offset checks the alignment of mem_addr.
        finish_test();

        start_test("hit_timing");
        idle_cycles(2);
        fetch(32'h0040_0a47);
        fetch(32'h0040_0a44); // back to back on the same line.
        idle_cycles(1);
        fetch(32'h0000_1234);
        finish_test();

        start_test("conflict_eviction");
        idle_cycles(1);
        for (n = 0; n < 4; n++) begin
            fetch(n[0] ? 32'h0002_0014 : 32'h0001_0014); // both tags share index 5.
            idle_cycles(1);
        end
        finish_test();

        start_test("flush");
        for (n = 0; n < 6; n++) begin
            if (n == 4) flush_cache(); // the last pair must miss with new words.
            fetch(n[0] ? 32'h0000_300c : 32'h0000_3008);
            idle_cycles(1);
        end
        finish_test();

        start_test("random_stream");
        for (n = 0; n < 300; n++) begin
            r = $random(seed);
            case (r[9:8])
                2'd2:    pick_tag = 26'h155_5555;
                2'd3:    pick_tag = 26'h2ab_cdef;
                default: pick_tag = 26'h000_0100; // the common tag keeps hits frequent.
            endcase
            if (r[14:10] == 5'd0) flush_cache();
            else if (r[15]) idle_cycles(1 + int'(r[17:16]));
            fetch({pick_tag, 1'b0, r[4:2], r[1:0]});
        end
        idle_cycles(2);
        finish_test();

        assert_fails = int'(u_dut.u_cache_control.u_checker.failures);
        if (assert_fails != 0) begin
            error_count += assert_fails;
            $display("%0d protocol assertions failed during the run", assert_fails);
        end
        $display("tests passed %0d, failed %0d, errors %0d, hits %0d, misses %0d",
                 tests_passed, tests_failed, error_count, hits, misses);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- testbench/icache_checker.sv
`timescale 1ns/100ps

module icache_checker (
    input logic                     clock,
    input logic                     reset,
    input logic                     ready,     // answer pulse of the controller.
    input logic                     mem_start, // memory read strobe.
    input icache_pkg::cache_state_e state      // controller state.
);

    int unsigned failures; // count of failed assertions, read by the testbench.

    initial failures = 0;

    mem_start_pulse: assert property (@(posedge clock) disable iff (reset)
        mem_start |=> !mem_start)
        else begin
            $error("mem_start stayed high for more than one cycle");
            failures++;
        end

    ready_pulse: assert property (@(posedge clock) disable iff (reset) ready |=> !ready)
        else begin
            $error("ready stayed high for more than one cycle");
            failures++;
        end

    // a read is only issued by a request sampled in idle.
    start_from_idle: assert property (@(posedge clock) disable iff (reset)
        $rose(mem_start) |-> $past(state) == icache_pkg::state_idle)
        else begin
            $error("mem_start rose while the controller was not idle");
            failures++;
        end

    reset_quiet: assert property (@(posedge clock) reset |=> !ready)
        else begin
            $error("ready was high in the cycle after reset");
            failures++;
        end

endmodule

bind cache_control icache_checker u_checker (
    .clock     (clock),
    .reset     (reset),
    .ready     (ready),
    .mem_start (mem_start),
    .state     (state)
);

//--- design/icache_top.sv
`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_top (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      valid,     // fetch request level.
    input  logic [`ICACHE_ADDR_W-1:0] addr,      // fetch address.
    output logic                      ready,     // answer pulse.
    output logic [31:0]               data,      // fetched instruction word.
    input  logic                      flush,     // invalidates every line.
    output logic                      mem_start, // memory read strobe.
    output logic [`ICACHE_ADDR_W-1:0] mem_addr,  // memory read address.
    input  logic                      mem_ok,    // memory answer strobe.
    input  logic [31:0]               mem_rdata  // memory answer word.
);

    cache_line_if lines (); // lookup and fill path shared by the three blocks.

    tag_store u_tag_store (
        .clock (clock),
        .reset (reset),
        .flush (flush),
        .lines (lines.tags)
    );

    data_store u_data_store (
        .clock (clock),
        .lines (lines.data)
    );

    cache_control u_cache_control (
        .clock     (clock),
        .reset     (reset),
        .valid     (valid),
        .addr      (addr),
        .mem_ok    (mem_ok),
        .mem_rdata (mem_rdata),
        .ready     (ready),
        .data      (data),
        .mem_start (mem_start),
        .mem_addr  (mem_addr),
        .lines     (lines.control)
    );

endmodule

//--- design/cache_control.sv
`timescale 1ns/100ps
`include "icache_defines.svh"

module cache_control (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      valid,     // fetch request level.
    input  logic [`ICACHE_ADDR_W-1:0] addr,      // held with valid until ready.
    input  logic                      mem_ok,    // memory answer strobe.
    input  logic [31:0]               mem_rdata, // memory answer word.
    output logic                      ready,     // one-cycle answer pulse.
    output logic [31:0]               data,      // fetched word, valid with ready.
    output logic                      mem_start, // one-cycle memory read strobe.
    output logic [`ICACHE_ADDR_W-1:0] mem_addr,  // word-aligned read address.
    cache_line_if.control             lines
);

    icache_pkg::cache_state_e state;      // current controller state.
    icache_pkg::cache_state_e state_next; // state after the next edge.

    logic lookup;     // a held request is sampled in idle this cycle.
    logic hit_take;   // the sampled request hits.
    logic miss_start; // the sampled request misses and needs memory.

    // the address is split once and shared by both stores.
    assign lines.index = addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign lines.tag   = addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];

    // the fill happens on the edge that samples mem_ok.
    assign lines.fill      = (state == icache_pkg::state_fetch) && mem_ok;
    assign lines.fill_word = mem_rdata; // memory word goes straight into the line.

    assign lookup     = (state == icache_pkg::state_idle) && valid;
    assign hit_take   = lookup && lines.hit;  // tag store and data store agree here.
    assign miss_start = lookup && !lines.hit; // memory has to be asked.

    assign ready = (state == icache_pkg::state_respond); // high for exactly one cycle.

    always_comb begin
        state_next = state; // hold by default.
        case (state)
            icache_pkg::state_idle: begin
                if (hit_take) begin
                    state_next = icache_pkg::state_respond; // answer from the cache.
                end else if (miss_start) begin
                    state_next = icache_pkg::state_fetch; // wait for memory.
                end
            end
            icache_pkg::state_fetch: begin
                if (mem_ok) begin
                    state_next = icache_pkg::state_respond; // line filled this edge.
                end
            end
            icache_pkg::state_respond: begin
                state_next = icache_pkg::state_idle; // a held valid is ignored here.
            end
            default: begin
                state_next = icache_pkg::state_idle; // unused encoding recovers.
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= icache_pkg::state_idle;
        end else begin
            state <= state_next;
        end
    end

    // memory read request. mem_addr stays put until the next miss.
    always_ff @(posedge clock) begin
        if (reset) begin
            mem_start <= 1'b0;
            mem_addr  <= '0;
        end else begin
            mem_start <= miss_start; // one cycle high because idle is left on the same edge.
            if (miss_start) begin
                mem_addr <= {addr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W],
                             {`ICACHE_OFFSET_W{1'b0}}}; // drop the byte offset.
            end
        end
    end

    // the answer word comes from the data store on a hit or from memory on a miss.
    always_ff @(posedge clock) begin
        if (reset) begin
            data <= '0;
        end else if (hit_take) begin
            data <= lines.word; // read combinationally at the request index.
        end else if (lines.fill) begin
            data <= mem_rdata; // same word that is written into the line.
        end
    end

endmodule

//--- design/data_store.sv
`timescale 1ns/100ps
`include "icache_defines.svh"

module data_store (
    input  logic       clock,
    cache_line_if.data lines
);

    logic [31:0] word_array [`ICACHE_LINES]; // one 32-bit word per line.

    // the lookup read is combinational so a hit answers in one cycle.
    assign lines.word = word_array[lines.index];

    // a fill writes the memory word at the index of the held request.
    always_ff @(posedge clock) begin
        if (lines.fill) begin
            word_array[lines.index] <= lines.fill_word; // same edge as the tag write.
        end
    end

endmodule

//--- design/tag_store.sv
`timescale 1ns/100ps
`include "icache_defines.svh"

module tag_store (
    input  logic          clock,
    input  logic          reset,
    input  logic          flush, // clears every line, as a fence.i does.
    cache_line_if.tags    lines
);

    logic [`ICACHE_TAG_W-1:0] tag_array [`ICACHE_LINES]; // one tag per line.
    logic [`ICACHE_LINES-1:0] valid_bits;                 // one valid bit per line.

    logic [`ICACHE_TAG_W-1:0] stored_tag; // tag read at the lookup index.
    logic                     line_valid; // valid bit read at the lookup index.

    assign stored_tag = tag_array[lines.index]; // combinational read at the index.
    assign line_valid = valid_bits[lines.index];

    // a hit needs both a live line and an equal tag.
    assign lines.hit = line_valid && (stored_tag == lines.tag);

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_bits <= '0; // every line starts empty.
        end else if (flush) begin
            valid_bits <= '0; // flush wins over a fill in the same cycle.
        end else if (lines.fill) begin
            valid_bits[lines.index] <= 1'b1; // the filled line becomes live.
        end
    end

    // the tag array is written on every fill.
    always_ff @(posedge clock) begin
        if (lines.fill) begin
            tag_array[lines.index] <= lines.tag; // written on the same edge as the word.
        end
    end

    // Note that a fill still writes its tag during a flush.
    // The line stays invalid, so the stale tag is never seen as a hit.

endmodule

//--- design/cache_line_if.sv
`timescale 1ns/100ps
`include "icache_defines.svh"

interface cache_line_if;

    logic [`ICACHE_INDEX_W-1:0] index;     // line selected by the current fetch address.
    logic [`ICACHE_TAG_W-1:0]   tag;       // upper address bits compared against the line.
    logic                       fill;      // one-cycle strobe that writes the line.
    logic [31:0]                fill_word; // word returned by memory on a miss.
    logic                       hit;       // line is valid and its tag matches.
    logic [31:0]                word;      // word currently held at the index.

    // the controller owns the lookup address and the fill.
    modport control (
        output index, tag, fill, fill_word,
        input  hit, word
    );

    // the tag store answers hit or miss.
    modport tags (
        input  index, tag, fill,
        output hit
    );

    // the data store answers with the word.
    modport data (
        input  index, fill, fill_word,
        output word
    );

endinterface

//--- design/icache_pkg.sv
package icache_pkg;

    // request controller states.
    // idle looks up a held request and decides hit or miss.
    // fetch waits for the memory answer after a miss.
    // respond is the single cycle in which ready is high.
    typedef enum logic [1:0] {
        state_idle    = 2'd0, // waiting for valid.
        state_fetch   = 2'd1, // memory read in flight.
        state_respond = 2'd2  // answer on data, ready high.
    } cache_state_e;

    // state_idle is also the reset state.
    // the fourth encoding is never entered and falls back to idle.

endpackage

//--- design/icache_defines.svh
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// fetch address geometry for the direct-mapped instruction cache.

`define ICACHE_ADDR_W 32 // width of a fetch address in bits.

`define ICACHE_OFFSET_W 2 // byte offset inside one 32-bit line.

`define ICACHE_INDEX_W 4 // line index bits, so the cache has 16 lines.

// the tag is whatever remains above the index and the offset.
`define ICACHE_TAG_W (`ICACHE_ADDR_W - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)

`define ICACHE_LINES (1 << `ICACHE_INDEX_W) // number of lines in the cache.

`endif
